// File: sim/exec_vectors.txt
// Columns: op (0 read, 1 write, 2 write with no idle gap and no busy poll, f end),
// APB address, write data or expected read data, expected pslverr
0 08 00000000 0
0 04 00000000 0
0 84 00000000 0
0 fc 00000000 0
// Preload x1 = -16 and x2 = 0x24
1 84 fffffff0 0
1 88 00000024 0
// R-type with rs1 x1 and rs2 x2 into x3 to x12
1 00 002081b3 0
0 8c 00000014 0
1 00 40208233 0
0 90 ffffffcc 0
1 00 002092b3 0
0 94 ffffff00 0
1 00 0020a333 0
0 98 00000001 0
1 00 0020b3b3 0
0 9c 00000000 0
1 00 0020c433 0
0 a0 ffffffd4 0
1 00 0020d4b3 0
0 a4 0fffffff 0
1 00 4020d533 0
0 a8 ffffffff 0
1 00 0020e5b3 0
0 ac fffffff4 0
1 00 0020f633 0
0 b0 00000020 0
// I-type into x13 to x21, then ADDI with rd x0
1 00 ffb08693 0
0 b4 ffffffeb 0
1 00 ff80a713 0
0 b8 00000001 0
1 00 fff0b793 0
0 bc 00000001 0
1 00 7ff0c813 0
0 c0 fffff80f 0
1 00 f0016893 0
0 c4 ffffff24 0
1 00 6f50f913 0
0 c8 000006f0 0
1 00 00809993 0
0 cc fffff000 0
1 00 00c0da13 0
0 d0 000fffff 0
1 00 4030da93 0
0 d4 fffffffe 0
1 00 00510013 0
0 80 00000000 0
// Shift length 3, then FCVT.S.W x22, FADD.S x23, FSUB.S x24
1 04 00000003 0
0 04 00000003 0
1 00 d0010b53 0
0 d8 00000120 0
1 00 00208bd3 0
0 dc 00000014 0
1 00 08208c53 0
0 e0 ffffffcc 0
// Illegal funct7 aimed at x3, which keeps its value
1 00 022081b3 0
0 8c 00000014 0
0 08 00000001 0
// Back-to-back INSTR writes, the second one is refused
2 00 00110d13 0
2 00 00210d93 1
0 e8 00000025 0
0 ec 00000000 0
// Unmapped address
1 0c 12345678 1
0 40 00000000 1
f 00 00000000 0

// File: exec_pipe_top.f
+incdir+common
common/rv_isa_pkg.sv
common/exec_bus_pkg.sv
hw/apb_issue_port.sv
hw/regfile.sv
hw/decode/instr_decoder.sv
hw/execute/alu.sv
hw/execute/exec_stage.sv
hw/exec_pipe_top.sv
sim/exec_pipe_sva.sv
sim/exec_pipe_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build with Verilator and run the testbench from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module exec_pipe_tb \
    -f exec_pipe_top.f -o exec_pipe_sim || { echo "build failed"; exit 1; }
out="$(./obj_dir/exec_pipe_sim 2>&1)"
echo "$out"
grep -q "ALL TESTS PASSED" <<< "$out" && exit 0 || exit 1

// File: sim/exec_pipe_tb.sv
/* Testbench for the execute cluster, clock and reset,
   APB driver, vector reader, compare task and watchdog */
`timescale 1ns/1ns
`include "exec_config.svh"
module exec_pipe_tb;
    localparam int MAX_VEC  = 128;
    localparam int CLK_HALF = 5;                   // 10 ns period

    logic                     clk;
    logic                     rst_n;
    logic [`EXEC_APB_AW-1:0]  paddr;
    logic                     psel;
    logic                     penable;
    logic                     pwrite;
    logic [`EXEC_XLEN-1:0]    pwdata;
    logic [`EXEC_XLEN-1:0]    prdata;
    logic                     pready;
    logic                     pslverr;

    logic [31:0] vec_mem [0:4*MAX_VEC-1];          // Four words per vector line
    int          n_vec;
    bit          loaded;

    exec_pipe_top DUT (
        .clk, .rst_n, .paddr, .psel, .penable, .pwrite, .pwdata,
        .prdata, .pready, .pslverr
    );

    always #CLK_HALF clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %08h expected %08h", $time, name, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
    endtask

    // Called 1 ns after an edge, returns 1 ns after the access edge
    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] data,
                            output logic [31:0] rdata, output logic err);
        psel    = 1'b1;                            // Setup phase
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1;
        penable = 1'b1;                            // Access phase
        @(negedge clk);
        rdata = prdata;                            // Settled mid-cycle
        err   = pslverr;
        check_value("pready", {31'b0, pready}, 32'h1);  // No wait states
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Poll STATUS until busy drops
    task automatic wait_not_busy();
        logic [31:0] st;
        logic        e;
        st = 32'h0000_8000;
        while (st[15])
            apb_xfer(1'b0, `EXEC_ADDR_STATUS, 32'h0, st, e);
    endtask

    initial begin
        logic [31:0] op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] exp_err;
        logic [31:0] rdata;
        logic        err;
        clk       = 1'b0;
        rst_n     = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        void'($urandom(32'h50c9_ef43));
        $readmemh("sim/exec_vectors.txt", vec_mem);
        n_vec = 0;
        while (n_vec < MAX_VEC && vec_mem[4*n_vec] !== 32'hf)
            n_vec++;                               // Stop at end marker
        loaded = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < n_vec; i++) begin
            op      = vec_mem[4*i];
            addr    = vec_mem[4*i+1];
            data    = vec_mem[4*i+2];
            exp_err = vec_mem[4*i+3];
            if (op != 32'h2)
                idle_cycles($urandom % 4);         // Back-to-back lines skip the gap
            apb_xfer(op != 32'h0, addr[7:0], data, rdata, err);
            check_value($sformatf("pslverr[%02h]", addr[7:0]), {31'b0, err}, exp_err);
            if (op == 32'h0)
                check_value($sformatf("prdata[%02h]", addr[7:0]), rdata, data);
            if (op == 32'h1 && addr[7:0] == `EXEC_ADDR_INSTR && !err)
                wait_not_busy();
        end
        if (n_vec > 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("no vectors were read from sim/exec_vectors.txt");
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // 20 cycles per vector plus reset
    initial begin
        wait (loaded);
        #((n_vec * 20 + 8) * 2 * CLK_HALF);
        $display("timeout: %0d vectors did not finish in the allowed time", n_vec);
        $display("SOME TESTS FAILED");
        $fatal(1);
    end

endmodule

// File: sim/exec_pipe_sva.sv
/* Bound checks on APB refusal, write-back
   following issue, and busy release */
`timescale 1ns/1ns
module exec_pipe_sva (
    input logic                clk,
    input logic                rst_n,
    input logic                psel,
    input logic                penable,
    input logic                pslverr,
    input logic                issue_valid,
    input logic                wb_en,
    input rv_isa_pkg::alu_op_e ex_op,
    input logic                busy
);

    a_refused_no_issue: assert property (@(posedge clk) disable iff (!rst_n)
        (psel && penable && pslverr) |=> !issue_valid)  // Refused access issues nothing
        else $error("instruction issued after an access answered with pslverr");

    a_wb_after_issue: assert property (@(posedge clk) disable iff (!rst_n)
        issue_valid |=> (wb_en || ex_op == rv_isa_pkg::ALU_ILLEGAL))
        else $error("no write-back one cycle after issue");

    a_wb_needs_issue: assert property (@(posedge clk) disable iff (!rst_n)
        wb_en |-> $past(issue_valid))              // No stray write-back
        else $error("write-back without an issue one cycle earlier");

    a_busy_release: assert property (@(posedge clk) disable iff (!rst_n)
        issue_valid |-> ##2 !busy)                 // Pipeline drains in two cycles
        else $error("busy still high after the pipeline should have drained");

endmodule

bind exec_pipe_top exec_pipe_sva u_sva (
    .clk, .rst_n, .psel, .penable, .pslverr, .issue_valid, .wb_en, .ex_op, .busy
);

// File: hw/exec_pipe_top.sv
/* Execute cluster top, APB issue port, register file,
   decode and execute stages */
`timescale 1ns/1ns
`include "exec_config.svh"
module exec_pipe_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`EXEC_APB_AW-1:0]  paddr,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [`EXEC_XLEN-1:0]    pwdata,
    output logic [`EXEC_XLEN-1:0]    prdata,
    output logic                     pready,
    output logic                     pslverr
);
    logic                        issue_valid;
    logic [`EXEC_XLEN-1:0]       issue_instr;
    logic [`EXEC_FLEN_W-1:0]     flen;
    logic                        busy;
    exec_bus_pkg::illegal_cnt_t  illegal_count;
    logic                        host_we;
    logic [`EXEC_RIDX_W-1:0]     host_waddr;
    logic [`EXEC_XLEN-1:0]       host_wdata;
    logic [`EXEC_RIDX_W-1:0]     host_raddr;
    logic [`EXEC_XLEN-1:0]       host_rdata;
    logic [`EXEC_RIDX_W-1:0]     rs1_addr;
    logic [`EXEC_RIDX_W-1:0]     rs2_addr;
    logic [`EXEC_XLEN-1:0]       rs1_data;
    logic [`EXEC_XLEN-1:0]       rs2_data;
    logic                        ex_valid;
    rv_isa_pkg::alu_op_e         ex_op;
    logic [`EXEC_RIDX_W-1:0]     ex_rd;
    logic [`EXEC_XLEN-1:0]       ex_rs1_data;
    logic [`EXEC_XLEN-1:0]       ex_rs2_data;
    logic [`EXEC_XLEN-1:0]       ex_imm;
    logic                        ex_use_imm;
    logic                        wb_en;
    logic [`EXEC_RIDX_W-1:0]     wb_addr;
    logic [`EXEC_XLEN-1:0]       wb_data;

    apb_issue_port u_apb (
        .clk, .rst_n, .paddr, .psel, .penable, .pwrite, .pwdata,
        .prdata, .pready, .pslverr, .issue_valid, .issue_instr, .flen,
        .busy_in (busy),                           // Refuses INSTR and reg writes
        .illegal_count, .host_we, .host_waddr, .host_wdata,
        .host_raddr, .host_rdata
    );

    regfile u_rf (
        .clk, .rst_n, .rs1_addr, .rs2_addr, .host_raddr,
        .rs1_data, .rs2_data, .host_rdata,
        .wb_en, .wb_addr, .wb_data, .host_we, .host_waddr, .host_wdata
    );

    instr_decoder u_dec (
        .clk, .rst_n, .issue_valid, .issue_instr,
        .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
        .ex_valid, .ex_op, .ex_rd, .ex_rs1_data, .ex_rs2_data, .ex_imm, .ex_use_imm
    );

    exec_stage u_ex (
        .clk, .rst_n, .issue_valid, .ex_valid, .ex_op, .ex_rd,
        .ex_rs1_data, .ex_rs2_data, .ex_imm, .ex_use_imm, .flen,
        .wb_en, .wb_addr, .wb_data, .illegal_count, .busy
    );

endmodule

// File: hw/execute/exec_stage.sv
/* Execute stage with ALU, write-back drive,
   illegal counter and pipeline busy */
`timescale 1ns/1ns
`include "exec_config.svh"
module exec_stage (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        issue_valid,
    input  logic                        ex_valid,
    input  rv_isa_pkg::alu_op_e         ex_op,
    input  logic [`EXEC_RIDX_W-1:0]     ex_rd,
    input  logic [`EXEC_XLEN-1:0]       ex_rs1_data,
    input  logic [`EXEC_XLEN-1:0]       ex_rs2_data,
    input  logic [`EXEC_XLEN-1:0]       ex_imm,
    input  logic                        ex_use_imm,
    input  logic [`EXEC_FLEN_W-1:0]     flen,
    output logic                        wb_en,
    output logic [`EXEC_RIDX_W-1:0]     wb_addr,
    output logic [`EXEC_XLEN-1:0]       wb_data,
    output exec_bus_pkg::illegal_cnt_t  illegal_count,
    output logic                        busy
);
    logic illegal;

    alu u_alu (
        .op       (ex_op),
        .flen     (flen),
        .rs1_data (ex_rs1_data),
        .rs2_data (ex_rs2_data),
        .imm      (ex_imm),
        .use_imm  (ex_use_imm),
        .result   (wb_data),
        .illegal  (illegal)
    );

    assign wb_en   = ex_valid & ~illegal;          // Regfile captures at end of this cycle
    assign wb_addr = ex_rd;
    assign busy    = issue_valid | ex_valid;       // Any stage occupied

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            illegal_count <= '0;
        else if (ex_valid && illegal && illegal_count != '1)
            illegal_count <= illegal_count + 1'b1; // Holds at 255
    end

endmodule

// File: hw/execute/alu.sv
/* Integer ALU for RV32I arithmetic and the FCVT.S.W,
   FADD.S and FSUB.S stand-ins, with illegal-op flag */
`timescale 1ns/1ns
`include "exec_config.svh"
module alu (
    input  rv_isa_pkg::alu_op_e      op,
    input  logic [`EXEC_FLEN_W-1:0]  flen,
    input  logic [`EXEC_XLEN-1:0]    rs1_data,
    input  logic [`EXEC_XLEN-1:0]    rs2_data,
    input  logic [`EXEC_XLEN-1:0]    imm,
    input  logic                     use_imm,
    output logic [`EXEC_XLEN-1:0]    result,
    output logic                     illegal
);
    logic [`EXEC_XLEN-1:0] op2;
    logic [4:0]            shamt;
    logic                  lt_s;
    logic                  lt_u;

    assign op2   = use_imm ? imm : rs2_data;       // Operand 2 select
    assign shamt = op2[4:0];                       // RV32 shift amount
    assign lt_s  = $signed(rs1_data) < $signed(op2);
    assign lt_u  = rs1_data < op2;

    always_comb begin
        result  = '0;
        illegal = 1'b0;
        case (op)
            rv_isa_pkg::ALU_ADDI,
            rv_isa_pkg::ALU_ADD,
            rv_isa_pkg::ALU_FADD:    result = rs1_data + op2;     // FADD.S as integer add
            rv_isa_pkg::ALU_SUB,
            rv_isa_pkg::ALU_FSUB:    result = rs1_data - op2;
            rv_isa_pkg::ALU_SLTI,
            rv_isa_pkg::ALU_SLT:     result[0] = lt_s;
            rv_isa_pkg::ALU_SLTIU,
            rv_isa_pkg::ALU_SLTU:    result[0] = lt_u;
            rv_isa_pkg::ALU_XORI,
            rv_isa_pkg::ALU_XOR:     result = rs1_data ^ op2;
            rv_isa_pkg::ALU_ORI,
            rv_isa_pkg::ALU_OR:      result = rs1_data | op2;
            rv_isa_pkg::ALU_ANDI,
            rv_isa_pkg::ALU_AND:     result = rs1_data & op2;
            rv_isa_pkg::ALU_SLLI,
            rv_isa_pkg::ALU_SLL:     result = rs1_data << shamt;
            rv_isa_pkg::ALU_SRLI,
            rv_isa_pkg::ALU_SRL:     result = rs1_data >> shamt;
            rv_isa_pkg::ALU_SRAI,
            rv_isa_pkg::ALU_SRA:     result = $signed(rs1_data) >>> shamt;  // Sign fill
            rv_isa_pkg::ALU_FCVT_SW: result = rs1_data << flen;   // Programmable scale
            default:                 illegal = 1'b1;              // ALU_ILLEGAL, result 0
        endcase
    end

endmodule

// File: hw/decode/instr_decoder.sv
/* Field split, I-type immediate, ALU op decode
   and the decode-to-execute pipeline register */
`timescale 1ns/1ns
`include "exec_config.svh"
module instr_decoder (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     issue_valid,
    input  logic [`EXEC_XLEN-1:0]    issue_instr,
    output logic [`EXEC_RIDX_W-1:0]  rs1_addr,
    output logic [`EXEC_RIDX_W-1:0]  rs2_addr,
    input  logic [`EXEC_XLEN-1:0]    rs1_data,
    input  logic [`EXEC_XLEN-1:0]    rs2_data,
    output logic                     ex_valid,
    output rv_isa_pkg::alu_op_e      ex_op,
    output logic [`EXEC_RIDX_W-1:0]  ex_rd,
    output logic [`EXEC_XLEN-1:0]    ex_rs1_data,
    output logic [`EXEC_XLEN-1:0]    ex_rs2_data,
    output logic [`EXEC_XLEN-1:0]    ex_imm,
    output logic                     ex_use_imm
);
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    rv_isa_pkg::alu_op_e op;

    assign opcode   = issue_instr[6:0];
    assign funct3   = issue_instr[14:12];
    assign funct7   = issue_instr[31:25];          // Also imm[11:5] for shifts
    assign rs1_addr = issue_instr[19:15];
    assign rs2_addr = issue_instr[24:20];

    always_comb begin
        op = rv_isa_pkg::ALU_ILLEGAL;
        case (opcode)
            rv_isa_pkg::OP_IMM: begin
                case (funct3)
                    rv_isa_pkg::F3_ADD:  op = rv_isa_pkg::ALU_ADDI;
                    rv_isa_pkg::F3_SLT:  op = rv_isa_pkg::ALU_SLTI;
                    rv_isa_pkg::F3_SLTU: op = rv_isa_pkg::ALU_SLTIU;
                    rv_isa_pkg::F3_XOR:  op = rv_isa_pkg::ALU_XORI;
                    rv_isa_pkg::F3_OR:   op = rv_isa_pkg::ALU_ORI;
                    rv_isa_pkg::F3_AND:  op = rv_isa_pkg::ALU_ANDI;
                    rv_isa_pkg::F3_SLL:
                        if (funct7 == rv_isa_pkg::F7_BASE) op = rv_isa_pkg::ALU_SLLI;
                    default:                           // Shift right, funct7 picks kind
                        if (funct7 == rv_isa_pkg::F7_BASE) op = rv_isa_pkg::ALU_SRLI;
                        else if (funct7 == rv_isa_pkg::F7_ALT) op = rv_isa_pkg::ALU_SRAI;
                endcase
            end
            rv_isa_pkg::OP_REG: begin
                case ({funct7, funct3})
                    {rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_ADD}:  op = rv_isa_pkg::ALU_ADD;
                    {rv_isa_pkg::F7_ALT,  rv_isa_pkg::F3_ADD}:  op = rv_isa_pkg::ALU_SUB;
                    {rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_SLL}:  op = rv_isa_pkg::ALU_SLL;
                    {rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_SLT}:  op = rv_isa_pkg::ALU_SLT;
                    {rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_SLTU}: op = rv_isa_pkg::ALU_SLTU;
                    {rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_XOR}:  op = rv_isa_pkg::ALU_XOR;
                    {rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_SR}:   op = rv_isa_pkg::ALU_SRL;
                    {rv_isa_pkg::F7_ALT,  rv_isa_pkg::F3_SR}:   op = rv_isa_pkg::ALU_SRA;
                    {rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_OR}:   op = rv_isa_pkg::ALU_OR;
                    {rv_isa_pkg::F7_BASE, rv_isa_pkg::F3_AND}:  op = rv_isa_pkg::ALU_AND;
                    default:                                    op = rv_isa_pkg::ALU_ILLEGAL;
                endcase
            end
            rv_isa_pkg::OP_FP: begin                   // funct3 ignored, as rounding mode
                case (funct7)
                    rv_isa_pkg::F7_FCVT_SW: op = rv_isa_pkg::ALU_FCVT_SW;
                    rv_isa_pkg::F7_BASE:    op = rv_isa_pkg::ALU_FADD;
                    rv_isa_pkg::F7_FSUB:    op = rv_isa_pkg::ALU_FSUB;
                    default:                op = rv_isa_pkg::ALU_ILLEGAL;
                endcase
            end
            default: op = rv_isa_pkg::ALU_ILLEGAL;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            ex_valid <= 1'b0;
        else
            ex_valid <= issue_valid;               // One cycle behind issue
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            ex_op       <= op;
            ex_rd       <= issue_instr[11:7];
            ex_rs1_data <= rs1_data;
            ex_rs2_data <= rs2_data;
            ex_imm      <= {{(`EXEC_XLEN-12){issue_instr[31]}}, issue_instr[31:20]};
            ex_use_imm  <= (opcode == rv_isa_pkg::OP_IMM);
        end
    end

endmodule

// File: hw/regfile.sv
/* Register file, two decode read ports, host read port,
   execute write-back and host preload write */
`timescale 1ns/1ns
`include "exec_config.svh"
module regfile (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`EXEC_RIDX_W-1:0]  rs1_addr,
    input  logic [`EXEC_RIDX_W-1:0]  rs2_addr,
    input  logic [`EXEC_RIDX_W-1:0]  host_raddr,
    output logic [`EXEC_XLEN-1:0]    rs1_data,
    output logic [`EXEC_XLEN-1:0]    rs2_data,
    output logic [`EXEC_XLEN-1:0]    host_rdata,
    input  logic                     wb_en,
    input  logic [`EXEC_RIDX_W-1:0]  wb_addr,
    input  logic [`EXEC_XLEN-1:0]    wb_data,
    input  logic                     host_we,
    input  logic [`EXEC_RIDX_W-1:0]  host_waddr,
    input  logic [`EXEC_XLEN-1:0]    host_wdata
);
    logic [`EXEC_XLEN-1:0] regs [`EXEC_NREGS];

    // Entry 0 is cleared at reset and never written, so x0 reads zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `EXEC_NREGS; i++)
                regs[i] <= '0;
        end else if (wb_en && wb_addr != '0) begin
            regs[wb_addr] <= wb_data;              // Execute write-back
        end else if (host_we && host_waddr != '0) begin
            regs[host_waddr] <= host_wdata;        // Host preload, only when idle
        end
    end

    assign rs1_data   = regs[rs1_addr];            // Combinational reads
    assign rs2_data   = regs[rs2_addr];
    assign host_rdata = regs[host_raddr];

endmodule

// File: hw/apb_issue_port.sv
/* APB slave with issue and shift-length registers,
   status readback and register-file window */
`timescale 1ns/1ns
`include "exec_config.svh"
module apb_issue_port (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [`EXEC_APB_AW-1:0]       paddr,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [`EXEC_XLEN-1:0]         pwdata,
    output logic [`EXEC_XLEN-1:0]         prdata,
    output logic                          pready,
    output logic                          pslverr,
    output logic                          issue_valid,
    output logic [`EXEC_XLEN-1:0]         issue_instr,
    output logic [`EXEC_FLEN_W-1:0]       flen,
    input  logic                          busy_in,
    input  exec_bus_pkg::illegal_cnt_t    illegal_count,
    output logic                          host_we,
    output logic [`EXEC_RIDX_W-1:0]       host_waddr,
    output logic [`EXEC_XLEN-1:0]         host_wdata,
    output logic [`EXEC_RIDX_W-1:0]       host_raddr,
    input  logic [`EXEC_XLEN-1:0]         host_rdata
);
    exec_bus_pkg::apb_target_e target;
    exec_bus_pkg::status_t     status;
    logic wr_acc;                                  // Write in its access cycle
    logic instr_wr;                                // Accepted INSTR write
    logic busy_ref;                                // Write refused while pipeline busy

    always_comb begin
        target = exec_bus_pkg::TGT_NONE;
        if (paddr[1:0] == 2'b00) begin             // Word aligned only
            if (paddr == `EXEC_ADDR_INSTR)
                target = exec_bus_pkg::TGT_INSTR;
            else if (paddr == `EXEC_ADDR_FLEN)
                target = exec_bus_pkg::TGT_FLEN;
            else if (paddr == `EXEC_ADDR_STATUS)
                target = exec_bus_pkg::TGT_STATUS;
            else if (paddr >= `EXEC_ADDR_REG_BASE)  // Top half is x0..x31
                target = exec_bus_pkg::TGT_REG;
        end
    end

    assign wr_acc   = psel & penable & pwrite;
    assign busy_ref = pwrite & busy_in & (target == exec_bus_pkg::TGT_INSTR ||
                                          target == exec_bus_pkg::TGT_REG);
    assign instr_wr = wr_acc & ~busy_in & (target == exec_bus_pkg::TGT_INSTR);

    assign pready  = 1'b1;                         // No wait states
    assign pslverr = psel & penable & (busy_ref | (target == exec_bus_pkg::TGT_NONE));

    assign host_raddr = paddr[`EXEC_RIDX_W+1:2];
    assign host_waddr = paddr[`EXEC_RIDX_W+1:2];
    assign host_wdata = pwdata;
    assign host_we    = wr_acc & ~busy_in & (target == exec_bus_pkg::TGT_REG);

    assign status = '{busy: busy_in, reserved: '0, illegal_count: illegal_count};

    always_comb begin
        case (target)
            exec_bus_pkg::TGT_INSTR:  prdata = issue_instr;     // Last issued word
            exec_bus_pkg::TGT_FLEN:   prdata = {{(`EXEC_XLEN-`EXEC_FLEN_W){1'b0}}, flen};
            exec_bus_pkg::TGT_STATUS: prdata = {{(`EXEC_XLEN-$bits(status)){1'b0}}, status};
            exec_bus_pkg::TGT_REG:    prdata = host_rdata;
            default:                  prdata = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issue_valid <= 1'b0;
            flen        <= `EXEC_FLEN_RESET;
        end else begin
            issue_valid <= instr_wr;               // Single-cycle pulse
            if (wr_acc && target == exec_bus_pkg::TGT_FLEN)
                flen <= pwdata[`EXEC_FLEN_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (instr_wr)
            issue_instr <= pwdata;
    end

endmodule

// File: common/exec_bus_pkg.sv
/* APB target decode enum and status word types */
package exec_bus_pkg;

    // Which block an APB address selects
    typedef enum logic [2:0] {
        TGT_NONE,                                  // Unmapped, answers with pslverr
        TGT_INSTR,
        TGT_FLEN,
        TGT_STATUS,
        TGT_REG                                    // Register file window
    } apb_target_e;

    typedef logic [7:0] illegal_cnt_t;             // Saturating count

    // Read back at the STATUS address, busy in bit 15
    typedef struct packed {
        logic         busy;
        logic [6:0]   reserved;
        illegal_cnt_t illegal_count;
    } status_t;

endpackage

// File: common/rv_isa_pkg.sv
/* RV32 opcode and funct field constants
   ALU operation encoding shared by decode and execute */
package rv_isa_pkg;

    localparam logic [6:0] OP_IMM = 7'b0010011;    // I-type arithmetic
    localparam logic [6:0] OP_REG = 7'b0110011;    // R-type arithmetic
    localparam logic [6:0] OP_FP  = 7'b1010011;    // F-extension integer stand-ins

    localparam logic [2:0] F3_ADD  = 3'b000;       // ADD, SUB, ADDI
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;       // SRL and SRA share funct3
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [6:0] F7_BASE    = 7'b0000000; // Plain ops, also FADD.S
    localparam logic [6:0] F7_ALT     = 7'b0100000; // SUB, SRA, SRAI
    localparam logic [6:0] F7_FCVT_SW = 7'b1101000;
    localparam logic [6:0] F7_FSUB    = 7'b0000100;

    // One code per supported instruction
    typedef enum logic [4:0] {
        ALU_ADDI, ALU_SLTI, ALU_SLTIU, ALU_XORI, ALU_ORI, ALU_ANDI,
        ALU_SLLI, ALU_SRLI, ALU_SRAI,
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
        ALU_FCVT_SW, ALU_FADD, ALU_FSUB,
        ALU_ILLEGAL                                // Anything not matched above
    } alu_op_e;

endpackage

// File: common/exec_config.svh
/* Data width, register count, APB address map and reset shift length */
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

`define EXEC_XLEN          32
`define EXEC_NREGS         32
`define EXEC_RIDX_W        5
`define EXEC_FLEN_W        5

`define EXEC_APB_AW        8
`define EXEC_ADDR_INSTR    8'h00
`define EXEC_ADDR_FLEN     8'h04
`define EXEC_ADDR_STATUS   8'h08
`define EXEC_ADDR_REG_BASE 8'h80

`define EXEC_FLEN_RESET    5'd0

`endif
